/* rtl/coreTypes.sv */
// shared widths, opcode enum and the structs passed between the execution units
// every RTL file refers to these through coreTypes:: scoped names

package coreTypes;

    localparam int dataWidth = 32;
    localparam int nameWidth = 5;
    // tag 0 means the value is present, 1..rsSize alu entries, above that ls entries
    localparam int tagWidth = 4;

    typedef logic [dataWidth-1:0] dataT;
    typedef logic [nameWidth-1:0] nameT;
    typedef logic [tagWidth-1:0] tagT;

    typedef enum logic [3:0] {
        opAdd,
        opSub,
        opAnd,
        opOr,
        opXor,
        opSlt,
        opAddi,
        opLw,
        opSw
    } opKind;

    // one renamed operation from the front end
    typedef struct packed {
        opKind op;
        nameT rs1;
        nameT rs2;
        nameT rd;
        dataT imm;
    } issueT;

    typedef struct packed {
        tagT tag;
        dataT data;
    } operandT;

    // result bus broadcast, valid for one cycle
    typedef struct packed {
        logic valid;
        tagT tag;
        nameT rd;
        dataT data;
    } resultT;

    // picks up a broadcast that carries the tag this operand waits on
    function automatic operandT forward(operandT cur, resultT busA, resultT busB);
        operandT upd;
        upd = cur;
        if (cur.tag != '0 && busA.valid && busA.tag == cur.tag) begin
            upd.tag = '0;
            upd.data = busA.data;
        end
        if (cur.tag != '0 && busB.valid && busB.tag == cur.tag) begin
            upd.tag = '0;
            upd.data = busB.data;
        end
        return upd;
    endfunction

endpackage

/* rtl/regFile.sv */
// architectural registers with rename tags
// commits both result buses and serves operand lookup for the issue stage

`timescale 1ns/1ps

module regFile (
    input  logic               clk_in,
    input  logic               rst,
    input  logic               rdy_in,
    input  logic               renameEn,
    input  coreTypes::issueT   issue,
    input  coreTypes::tagT     newTag,
    input  coreTypes::resultT  aluResult,
    input  coreTypes::resultT  lsResult,
    input  coreTypes::nameT    dbgName,
    output coreTypes::operandT src1,
    output coreTypes::operandT src2,
    output coreTypes::dataT    dbgData
);

    // tag and data per register, x0 is never renamed so it stays zero
    coreTypes::operandT regs [32];
    logic doRename;

    // stores have no destination
    assign doRename = renameEn
                      && issue.rd != '0
                      && issue.op != coreTypes::opSw;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rdy_in) begin
            // only the newest writer's tag matches, older results fall through
            for (int i = 1; i < 32; i++) begin
                regs[i] <= coreTypes::forward(regs[i], aluResult, lsResult);
            end
            // rename after commit so a new tag wins over a same-cycle clear
            if (doRename) begin
                regs[issue.rd].tag <= newTag;
            end
        end
    end

    // lookup sees a result that lands in the issue cycle
    always_comb begin
        src1 = coreTypes::forward(regs[issue.rs1], aluResult, lsResult);
        src2 = coreTypes::forward(regs[issue.rs2], aluResult, lsResult);
    end

    assign dbgData = regs[dbgName].data;

endmodule

/* rtl/aluStation.sv */
// arithmetic reservation station with its ALU
// holds rsSize waiting ops, fires the lowest ready one and registers the result

`timescale 1ns/1ps

module aluStation #(
    parameter int rsSize = 4
) (
    input  logic               clk_in,
    input  logic               rst,
    input  logic               rdy_in,
    input  logic               dispatchEn,
    input  coreTypes::issueT   issue,
    input  coreTypes::operandT src1,
    input  coreTypes::operandT src2,
    input  coreTypes::resultT  lsResult,
    output coreTypes::tagT     newTag,
    output logic               hasFree,
    output logic               empty,
    output coreTypes::resultT  aluResult
);

    localparam int idxWidth = (rsSize > 1) ? $clog2(rsSize) : 1;

    typedef logic [idxWidth-1:0] idxT;

    typedef struct packed {
        logic valid;
        coreTypes::opKind op;
        coreTypes::operandT a;
        coreTypes::operandT b;
        coreTypes::nameT rd;
    } entryT;

    entryT entries [rsSize];
    idxT pick;
    idxT freeIdx;
    logic anyReady;
    logic anyValid;
    coreTypes::operandT opB;

    function automatic coreTypes::dataT compute(coreTypes::opKind op, coreTypes::dataT a,
                                                coreTypes::dataT b);
        case (op)
            coreTypes::opSub: return a - b;
            coreTypes::opAnd: return a & b;
            coreTypes::opOr:  return a | b;
            coreTypes::opXor: return a ^ b;
            coreTypes::opSlt: return coreTypes::dataT'($signed(a) < $signed(b));
            default:          return a + b;
        endcase
    endfunction

    // lowest index wins for both the ready pick and the free slot
    always_comb begin
        anyReady = 1'b0;
        anyValid = 1'b0;
        hasFree = 1'b0;
        pick = '0;
        freeIdx = '0;
        for (int i = rsSize - 1; i >= 0; i--) begin
            if (entries[i].valid && entries[i].a.tag == '0 && entries[i].b.tag == '0) begin
                anyReady = 1'b1;
                pick = idxT'(i);
            end
            if (entries[i].valid) begin
                anyValid = 1'b1;
            end else begin
                hasFree = 1'b1;
                freeIdx = idxT'(i);
            end
        end
    end

    // addi takes the immediate as an operand that is already present
    always_comb begin
        opB = src2;
        if (issue.op == coreTypes::opAddi) begin
            opB.tag = '0;
            opB.data = issue.imm;
        end
    end

    assign newTag = coreTypes::tagT'(freeIdx) + coreTypes::tagT'(1);
    // a registered result still counts until the register file has it
    assign empty = !anyValid && !aluResult.valid;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < rsSize; i++) begin
                entries[i].valid <= 1'b0;
            end
            aluResult.valid <= 1'b0;
        end else if (rdy_in) begin
            for (int i = 0; i < rsSize; i++) begin
                entries[i].a <= coreTypes::forward(entries[i].a, aluResult, lsResult);
                entries[i].b <= coreTypes::forward(entries[i].b, aluResult, lsResult);
            end
            aluResult.valid <= anyReady;
            aluResult.tag <= coreTypes::tagT'(pick) + coreTypes::tagT'(1);
            aluResult.rd <= entries[pick].rd;
            aluResult.data <= compute(entries[pick].op, entries[pick].a.data,
                                      entries[pick].b.data);
            // slot frees as its result is registered
            if (anyReady) begin
                entries[pick].valid <= 1'b0;
            end
            if (dispatchEn) begin
                entries[freeIdx].valid <= 1'b1;
                entries[freeIdx].op <= issue.op;
                entries[freeIdx].a <= src1;
                entries[freeIdx].b <= opB;
                entries[freeIdx].rd <= issue.rd;
            end
        end
    end

endmodule

/* rtl/lsQueue.sv */
// in-order load/store queue in front of the memory sequencer
// the head starts its access once base and store data are present

`timescale 1ns/1ps

module lsQueue #(
    parameter int rsSize = 4,
    parameter int memAddrWidth = 17
) (
    input  logic                    clk_in,
    input  logic                    rst,
    input  logic                    rdy_in,
    input  logic                    dispatchEn,
    input  coreTypes::issueT        issue,
    input  coreTypes::operandT      src1,
    input  coreTypes::operandT      src2,
    input  coreTypes::resultT       aluResult,
    input  logic                    memBusy,
    input  logic                    memDone,
    input  coreTypes::dataT         memRData,
    output coreTypes::tagT          newTag,
    output logic                    hasFree,
    output logic                    empty,
    output logic                    memStart,
    output logic                    memWrite,
    output logic [memAddrWidth-1:0] memAddr,
    output coreTypes::dataT         memWData,
    output coreTypes::resultT       lsResult
);

    localparam int idxWidth = (rsSize > 1) ? $clog2(rsSize) : 1;

    typedef logic [idxWidth-1:0] idxT;

    typedef struct packed {
        logic valid;
        logic isStore;
        coreTypes::operandT base;
        coreTypes::operandT wdata;
        coreTypes::dataT imm;
        coreTypes::nameT rd;
    } entryT;

    entryT entries [rsSize];
    idxT head;
    idxT tail;
    // head access handed to memPort, waiting for memDone
    logic started;
    logic headGo;
    coreTypes::dataT headAddr;

    function automatic idxT bump(idxT p);
        return (p == idxT'(rsSize - 1)) ? '0 : p + 1'b1;
    endfunction

    // ls tags sit above the alu range
    function automatic coreTypes::tagT slotTag(idxT p);
        return coreTypes::tagT'(p) + coreTypes::tagT'(rsSize + 1);
    endfunction

    assign newTag = slotTag(tail);
    assign hasFree = !entries[tail].valid;
    assign empty = !entries[head].valid && !lsResult.valid;
    assign headAddr = entries[head].base.data + entries[head].imm;
    assign headGo = entries[head].valid && !started && !memBusy
                    && entries[head].base.tag == '0
                    && entries[head].wdata.tag == '0;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            for (int i = 0; i < rsSize; i++) begin
                entries[i].valid <= 1'b0;
            end
            head <= '0;
            tail <= '0;
            started <= 1'b0;
            memStart <= 1'b0;
            lsResult.valid <= 1'b0;
        end else if (rdy_in) begin
            for (int i = 0; i < rsSize; i++) begin
                entries[i].base <= coreTypes::forward(entries[i].base, aluResult, lsResult);
                entries[i].wdata <= coreTypes::forward(entries[i].wdata, aluResult, lsResult);
            end
            memStart <= headGo;
            if (headGo) begin
                started <= 1'b1;
                memWrite <= entries[head].isStore;
                memAddr <= headAddr[memAddrWidth-1:0];
                memWData <= entries[head].wdata.data;
            end
            lsResult.valid <= 1'b0;
            if (memDone && started) begin
                entries[head].valid <= 1'b0;
                started <= 1'b0;
                head <= bump(head);
                // only loads broadcast
                lsResult.valid <= !entries[head].isStore;
                lsResult.tag <= slotTag(head);
                lsResult.rd <= entries[head].rd;
                lsResult.data <= memRData;
            end
            if (dispatchEn) begin
                entries[tail].valid <= 1'b1;
                entries[tail].isStore <= issue.op == coreTypes::opSw;
                entries[tail].base <= src1;
                // loads never wait on rs2
                entries[tail].wdata <= (issue.op == coreTypes::opSw) ? src2 : '0;
                entries[tail].imm <= issue.imm;
                entries[tail].rd <= issue.rd;
                tail <= bump(tail);
            end
        end
    end

endmodule

/* rtl/memPort.sv */
// byte-serial memory sequencer for word loads and stores
// a load presents four addresses and finishes as the last byte arrives

`timescale 1ns/1ps

module memPort #(
    parameter int memAddrWidth = 17
) (
    input  logic                    clk_in,
    input  logic                    rst,
    input  logic                    rdy_in,
    input  logic                    memStart,
    input  logic                    memWrite,
    input  logic [memAddrWidth-1:0] memAddr,
    input  coreTypes::dataT         memWData,
    input  logic [7:0]              mem_din,
    output logic                    memBusy,
    output logic                    memDone,
    output coreTypes::dataT         memRData,
    output logic [7:0]              mem_dout,
    output logic [memAddrWidth-1:0] mem_a,
    output logic                    mem_wr
);

    typedef enum logic [1:0] {
        stIdle,
        stReading,
        stReadTail,
        stWriting
    } stateT;

    stateT state;
    logic [1:0] byteCnt;
    logic [memAddrWidth-1:0] addrReg;
    // store data shifts out low byte first, load data shifts in from the top
    coreTypes::dataT word;

    always_ff @(posedge clk_in) begin
        if (rst) begin
            state <= stIdle;
            byteCnt <= '0;
            addrReg <= '0;
        end else if (rdy_in) begin
            case (state)
                stIdle: begin
                    if (memStart) begin
                        addrReg <= memAddr;
                        word <= memWData;
                        byteCnt <= '0;
                        state <= memWrite ? stWriting : stReading;
                    end
                end
                stReading: begin
                    // ram answers one cycle late, nothing to take on the first address
                    if (byteCnt != 2'd0) begin
                        word <= {mem_din, word[coreTypes::dataWidth-1:8]};
                    end
                    if (byteCnt == 2'd3) begin
                        state <= stReadTail;
                    end else begin
                        addrReg <= addrReg + 1'b1;
                        byteCnt <= byteCnt + 1'b1;
                    end
                end
                stReadTail: begin
                    state <= stIdle;
                end
                stWriting: begin
                    if (byteCnt == 2'd3) begin
                        state <= stIdle;
                    end else begin
                        addrReg <= addrReg + 1'b1;
                        word <= word >> 8;
                        byteCnt <= byteCnt + 1'b1;
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    assign memBusy = state != stIdle;
    assign memDone = state == stReadTail || (state == stWriting && byteCnt == 2'd3);
    // last byte comes straight off the bus
    assign memRData = {mem_din, word[coreTypes::dataWidth-1:8]};
    assign mem_dout = word[7:0];
    assign mem_a = addrReg;
    assign mem_wr = state == stWriting && rdy_in;

endmodule

/* rtl/execCore.sv */
// out-of-order execution back end, top level
// joins register file, both stations and the memory sequencer on the external bus

`timescale 1ns/1ps

module execCore #(
    parameter int rsSize = 4,
    parameter int memAddrWidth = 17
) (
    input  logic                    clk_in,
    input  logic                    rst,
    input  logic                    rdy_in,
    input  logic                    issueEn,
    input  coreTypes::issueT        issue,
    input  logic [7:0]              mem_din,
    input  coreTypes::nameT         dbgName,
    output logic                    free,
    output logic                    idle,
    output logic [7:0]              mem_dout,
    output logic [memAddrWidth-1:0] mem_a,
    output logic                    mem_wr,
    output coreTypes::dataT         dbgData
);

    coreTypes::operandT src1;
    coreTypes::operandT src2;
    coreTypes::resultT aluResult;
    coreTypes::resultT lsResult;
    coreTypes::tagT aluTag;
    coreTypes::tagT lsTag;
    coreTypes::tagT newTag;
    logic accept;
    logic isMem;
    logic aluFree;
    logic lsFree;
    logic aluEmpty;
    logic lsEmpty;
    logic memStart;
    logic memWrite;
    logic [memAddrWidth-1:0] memAddr;
    coreTypes::dataT memWData;
    logic memBusy;
    logic memDone;
    coreTypes::dataT memRData;

    assign isMem = issue.op == coreTypes::opLw || issue.op == coreTypes::opSw;
    // units gate their own state with rdy_in
    assign accept = issueEn && free;
    assign newTag = isMem ? lsTag : aluTag;
    assign free = aluFree && lsFree;
    assign idle = aluEmpty && lsEmpty && !memBusy;

    regFile regs (
        .clk_in, .rst, .rdy_in,
        .renameEn(accept), .issue, .newTag,
        .aluResult, .lsResult,
        .dbgName, .src1, .src2, .dbgData
    );

    aluStation #(.rsSize(rsSize)) alu (
        .clk_in, .rst, .rdy_in,
        .dispatchEn(accept && !isMem), .issue, .src1, .src2,
        .lsResult,
        .newTag(aluTag), .hasFree(aluFree), .empty(aluEmpty), .aluResult
    );

    lsQueue #(.rsSize(rsSize), .memAddrWidth(memAddrWidth)) lsq (
        .clk_in, .rst, .rdy_in,
        .dispatchEn(accept && isMem), .issue, .src1, .src2,
        .aluResult,
        .memBusy, .memDone, .memRData,
        .newTag(lsTag), .hasFree(lsFree), .empty(lsEmpty),
        .memStart, .memWrite, .memAddr, .memWData,
        .lsResult
    );

    memPort #(.memAddrWidth(memAddrWidth)) mem (
        .clk_in, .rst, .rdy_in,
        .memStart, .memWrite, .memAddr, .memWData,
        .mem_din,
        .memBusy, .memDone, .memRData,
        .mem_dout, .mem_a, .mem_wr
    );

endmodule

/* verification/byteRam.sv */
// byte memory on the external bus of the execution core
// read data appears one cycle after its address, a write lands on the clock edge

`timescale 1ns/1ps

module byteRam #(
    parameter int addrWidth = 17
) (
    input  logic                 clk_in,
    input  logic                 en,
    input  logic [addrWidth-1:0] a,
    input  logic                 wr,
    input  logic [7:0]           din,
    output logic [7:0]           dout
);

    logic [7:0] mem [2**addrWidth];

    // fill mixes every address bit so a misrouted byte shows up
    initial begin
        for (int i = 0; i < 2**addrWidth; i++) begin
            mem[i] = 8'(i * 7) ^ 8'(i >> 8) ^ 8'(i >> 16);
        end
    end

    always @(posedge clk_in) begin
        if (wr) begin
            mem[a] <= din;
        end
        // read register holds while the core is frozen
        if (en) begin
            dout <= mem[a];
        end
    end

endmodule

/* verification/execCoreTb.sv */
// testbench for the execution core, random issue stream against an in-order model
// byteRam serves the memory bus, registers come back through the debug port

`timescale 1ns/1ps

module execCoreTb;

    localparam int rsSize = 4;
    localparam int memAddrWidth = 17;
    localparam int idleTimeout = 400;

    typedef logic [memAddrWidth-1:0] addrT;

    logic clk_in;
    logic rst;
    logic rdy_in;
    logic issueEn;
    coreTypes::issueT issue;
    logic [7:0] mem_din;
    coreTypes::nameT dbgName;
    logic free;
    logic idle;
    logic [7:0] mem_dout;
    addrT mem_a;
    logic mem_wr;
    coreTypes::dataT dbgData;

    integer seed;
    int accepted;
    int rdyLeft;
    coreTypes::dataT storeWord;
    coreTypes::dataT readBack;
    // in-order reference state
    coreTypes::dataT modelRegs [32];
    logic [7:0] modelMem [256];

    execCore #(.rsSize(rsSize), .memAddrWidth(memAddrWidth)) dut (
        .clk_in, .rst, .rdy_in, .issueEn, .issue, .mem_din, .dbgName,
        .free, .idle, .mem_dout, .mem_a, .mem_wr, .dbgData
    );

    byteRam #(.addrWidth(memAddrWidth)) ram (
        .clk_in, .en(rdy_in), .a(mem_a), .wr(mem_wr), .din(mem_dout), .dout(mem_din)
    );

    always #2 clk_in = ~clk_in;

    task automatic stopRun();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkReg(input coreTypes::nameT name, input coreTypes::dataT expected,
                            input coreTypes::dataT actual);
        if (actual !== expected) begin
            $display("FAILED time=%0t signal=dbgData[x%0d] expected=%h actual=%h",
                     $time, name, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkByte(input addrT addr, input logic [7:0] expected,
                             input logic [7:0] actual);
        if (actual !== expected) begin
            $display("FAILED time=%0t signal=ram.mem[%h] expected=%h actual=%h",
                     $time, addr, expected, actual);
            stopRun();
        end
    endtask

    task automatic checkLevel(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED time=%0t signal=%s expected=%b actual=%b",
                     $time, name, expected, actual);
            stopRun();
        end
    endtask

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % 32'(n));
    endfunction

    function automatic coreTypes::issueT makeOp(input coreTypes::opKind kind, input int rs1,
                                                input int rs2, input int rd,
                                                input coreTypes::dataT imm);
        coreTypes::issueT inst;
        inst.op = kind;
        inst.rs1 = coreTypes::nameT'(rs1);
        inst.rs2 = coreTypes::nameT'(rs2);
        inst.rd = coreTypes::nameT'(rd);
        inst.imm = imm;
        return inst;
    endfunction

    // small register window keeps dependencies dense, x1 stays the zero base
    function automatic coreTypes::issueT randomOp(input bit withMem);
        coreTypes::issueT inst;
        int kind;
        int rd;
        kind = withMem ? randBelow(10) : randBelow(7);
        rd = randBelow(8);
        if (rd == 1) begin
            rd = 0;
        end
        inst = makeOp(coreTypes::opKind'(4'(kind)), randBelow(8), randBelow(8), rd,
                      $random(seed));
        if (kind >= 7) begin
            inst.op = (kind == 7) ? coreTypes::opSw : coreTypes::opLw;
            inst.rs1 = 5'd1;
            inst.imm = coreTypes::dataT'(4 * randBelow(64));
        end
        return inst;
    endfunction

    task automatic applyModel(input coreTypes::issueT inst);
        coreTypes::dataT a;
        coreTypes::dataT b;
        coreTypes::dataT res;
        int addr;
        a = modelRegs[inst.rs1];
        b = modelRegs[inst.rs2];
        addr = int'(8'(a + inst.imm));
        case (inst.op)
            coreTypes::opAdd:  res = a + b;
            coreTypes::opSub:  res = a - b;
            coreTypes::opAnd:  res = a & b;
            coreTypes::opOr:   res = a | b;
            coreTypes::opXor:  res = a ^ b;
            coreTypes::opSlt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            coreTypes::opAddi: res = a + inst.imm;
            coreTypes::opLw: begin
                res = {modelMem[addr + 3], modelMem[addr + 2],
                       modelMem[addr + 1], modelMem[addr]};
            end
            default:           res = '0;
        endcase
        if (inst.op == coreTypes::opSw) begin
            // little-endian, byte i at address plus i
            for (int i = 0; i < 4; i++) begin
                modelMem[addr + i] = b[8*i +: 8];
            end
        end else if (inst.rd != '0) begin
            modelRegs[inst.rd] = res;
        end
    endtask

    // one stimulus cycle, the op counts only if the core takes it on the next edge
    task automatic driveCycle(input bit withMem, input bit toggleRdy);
        coreTypes::issueT inst;
        @(posedge clk_in);
        #1;
        if (toggleRdy) begin
            // rdy_in keeps its level until the stretch runs out
            if (rdyLeft == 0) begin
                rdy_in = randBelow(4) != 0;
                rdyLeft = 1 + randBelow(4);
            end
            rdyLeft--;
        end else begin
            rdy_in = 1'b1;
        end
        inst = randomOp(withMem);
        issueEn = free && randBelow(4) != 0;
        issue = inst;
        if (issueEn && rdy_in) begin
            applyModel(inst);
            accepted++;
        end
    endtask

    task automatic issueOne(input coreTypes::issueT inst);
        int cycles;
        cycles = 0;
        @(posedge clk_in);
        #1;
        rdy_in = 1'b1;
        issueEn = 1'b0;
        while (!free) begin
            cycles++;
            if (cycles > idleTimeout) begin
                $display("free stayed low while issuing a directed op at %0t", $time);
                stopRun();
            end
            @(posedge clk_in);
            #1;
        end
        issueEn = 1'b1;
        issue = inst;
        applyModel(inst);
    endtask

    task automatic waitIdle();
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk_in);
            #1;
            issueEn = 1'b0;
            rdy_in = 1'b1;
            cycles++;
            if (cycles > idleTimeout) begin
                $display("core did not drain within %0d cycles at %0t", idleTimeout, $time);
                stopRun();
            end
        end while (!idle);
        checkLevel("free", 1'b1, free);
    endtask

    task automatic runStream(input int count, input bit withMem, input bit toggleRdy);
        int target;
        int cycles;
        target = accepted + count;
        cycles = 0;
        rdyLeft = 0;
        while (accepted < target) begin
            driveCycle(withMem, toggleRdy);
            cycles++;
            if (cycles > count * 40) begin
                $display("issue stream stalled, %0d ops still pending", target - accepted);
                stopRun();
            end
        end
        waitIdle();
    endtask

    task automatic readReg(input coreTypes::nameT name, output coreTypes::dataT value);
        @(posedge clk_in);
        #1;
        dbgName = name;
        #1;
        value = dbgData;
    endtask

    task automatic compareRegs();
        coreTypes::dataT value;
        for (int i = 0; i < 32; i++) begin
            readReg(coreTypes::nameT'(i), value);
            checkReg(coreTypes::nameT'(i), modelRegs[i], value);
        end
    endtask

    task automatic compareMem();
        for (int i = 0; i < 256; i++) begin
            checkByte(addrT'(i), modelMem[i], ram.mem[i]);
        end
    endtask

    // a frozen core keeps the bus quiet, a drained core takes issue
    always @(posedge clk_in) begin
        #3;
        if (!rst && !rdy_in && mem_wr) begin
            $display("mem_wr was high while rdy_in was low at %0t", $time);
            stopRun();
        end
        if (!rst && idle && !free) begin
            $display("free was low although both stations were empty at %0t", $time);
            stopRun();
        end
    end

    initial begin
        seed = 33;
        clk_in = 1'b0;
        rst = 1'b1;
        rdy_in = 1'b1;
        issueEn = 1'b0;
        issue = '0;
        dbgName = '0;
        accepted = 0;
        rdyLeft = 0;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        repeat (3) @(posedge clk_in);
        #1;
        rst = 1'b0;
        for (int i = 0; i < 256; i++) begin
            modelMem[i] = ram.mem[i];
        end

        checkLevel("free", 1'b1, free);
        checkLevel("idle", 1'b1, idle);
        checkLevel("mem_wr", 1'b0, mem_wr);
        compareRegs();

        // arithmetic only, rdy_in held high
        runStream(60, 1'b0, 1'b0);
        compareRegs();

        // store then load of the same word
        storeWord = 32'ha1b2c3d4;
        issueOne(makeOp(coreTypes::opAddi, 0, 0, 5, storeWord));
        issueOne(makeOp(coreTypes::opSw, 1, 5, 0, 32'h40));
        issueOne(makeOp(coreTypes::opLw, 1, 0, 6, 32'h40));
        waitIdle();
        readReg(5'd6, readBack);
        checkReg(5'd6, storeWord, readBack);
        for (int i = 0; i < 4; i++) begin
            checkByte(addrT'(32'h40 + i), storeWord[8*i +: 8], ram.mem[32'h40 + i]);
        end

        // mixed bursts with rdy_in stretches
        for (int burst = 0; burst < 8; burst++) begin
            runStream(50, 1'b1, 1'b1);
        end
        compareRegs();
        compareMem();

        $display("Test passed");
        $finish;
    end

endmodule

/* tb.f */
rtl/coreTypes.sv
rtl/regFile.sv
rtl/aluStation.sv
rtl/lsQueue.sv
rtl/memPort.sv
rtl/execCore.sv
verification/byteRam.sv
verification/execCoreTb.sv

/* run.sh */
#!/usr/bin/env bash
# builds the execution core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f --top-module execCoreTb \
    --Mdir obj_dir -o execCoreTbSim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/execCoreTbSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
fi

if grep -qx "Test passed" sim.log; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
